// File: dv/packet_fifo_asserts.sv
`timescale 1ns/1ns

module packet_fifo_asserts #(
	parameter int depth = packet_fifo_pkg::default_depth,
	localparam int addr_bits = $clog2(depth)
) (
	input logic                          rd_clk,
	input logic                          rd_reset,
	input logic                          rd_pop,
	input logic [addr_bits:0]            rd_len,
	input logic                          rd_len_valid,
	input packet_fifo_pkg::fifo_rd_ctl_t len_ctl,
	input packet_fifo_pkg::fifo_rd_ctl_t data_ctl
);

	int fail_count = 0;		// Assertion failures so far

	// Pop only against a presented length
	pop_when_valid: assert property (@(posedge rd_clk) disable iff (rd_reset)
		rd_pop |-> rd_len_valid)
		else begin
			fail_count++;
			$error("rd_pop seen while rd_len_valid is low");
		end

	// One pop kind per FIFO per cycle
	one_pop_kind: assert property (@(posedge rd_clk) disable iff (rd_reset)
		!(len_ctl.pop_single && len_ctl.pop_packet) &&
		!(data_ctl.pop_single && data_ctl.pop_packet))
		else begin
			fail_count++;
			$error("pop_single and pop_packet raised together");
		end

	// Empty packets never reach the reader
	len_nonzero: assert property (@(posedge rd_clk) disable iff (rd_reset)
		rd_len_valid |-> (rd_len != '0))
		else begin
			fail_count++;
			$error("rd_len_valid high with a zero length");
		end

endmodule

bind packet_read_sequencer packet_fifo_asserts #(.depth(depth)) u_asserts (
	.rd_clk(rd_clk), .rd_reset(rd_reset), .rd_pop(rd_pop),
	.rd_len(rd_len), .rd_len_valid(rd_len_valid),
	.len_ctl(len_ctl), .data_ctl(data_ctl)
);

// File: dv/packet_fifo_tb.sv
`timescale 1ns/1ns

module packet_fifo_tb;

	import packet_fifo_pkg::*;

	localparam int width       = default_width;
	localparam int depth       = default_depth;
	localparam int addr_bits   = $clog2(depth);
	localparam int rd_period   = 8;
	localparam int wr_period   = 10;		// Write clock, deliberately unrelated to rd_clk
	localparam int num_packets = 60;
	localparam int max_len     = 32;
	localparam int watchdog_ns = num_packets * max_len * 40 + 5000;

	logic                 wr_clk, wr_reset, wr_en, wr_last, wr_abort;
	logic [width-1:0]     wr_data;
	logic [addr_bits:0]   wr_size;
	logic                 rd_clk, rd_reset, rd_en, rd_pop, rd_len_valid;
	logic [addr_bits-1:0] rd_offset;
	logic [width-1:0]     rd_data;
	logic [addr_bits:0]   rd_len;

	// Reference model, committed words in order plus one length per packet
	logic [width-1:0] model_words[$];
	int               model_lens[$];
	int               held_words;		// Committed words not yet popped
	int               committed_pkts;
	int               popped_pkts;
	bit               write_done;
	int               error_count;
	int               check_count;

	packet_fifo_top #(.width(width), .depth(depth)) uut (.*);

	always #(rd_period / 2) rd_clk = !rd_clk;
	always #(wr_period / 2) wr_clk = !wr_clk;

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	// Step to 1 ns past the next edge, outputs settled and inputs safe to change
	task automatic wr_tick();
		@(posedge wr_clk);
		#1;
	endtask

	task automatic rd_tick();
		@(posedge rd_clk);
		#1;
	endtask

	task automatic check_value(input string test_name, input logic [width-1:0] expected,
			input logic [width-1:0] actual);
		check_count++;
		assert (expected == actual) else begin
			error_count++;
			$display("FAILED %s: expected %0h, actual %0h", test_name, expected, actual);
		end
	endtask

	// wr_size may lag a pop but must never overstate the room
	task automatic check_free_space();
		check_count++;
		assert (int'(wr_size) <= depth - held_words) else begin
			error_count++;
			$display("FAILED free_space: expected at most %0d, actual %0d",
				depth - held_words, wr_size);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Write side

	task automatic send_packet(input int len, input bit abort);
		logic [width-1:0] words[$];
		int               n_words;
		n_words = abort ? 1 + ($urandom % len) : len;	// Aborts stop somewhere inside
		while (int'(wr_size) < n_words) begin			// Writer rule, no overflow
			check_free_space();
			wr_tick();
		end
		check_free_space();
		for (int i = 0; i < n_words; i++) begin
			words.push_back($urandom);
			wr_en   = 1'b1;
			wr_data = words[i];
			wr_last = !abort && (i == n_words - 1);
			wr_tick();
		end
		wr_en   = 1'b0;
		wr_last = 1'b0;
		if (abort) begin
			wr_abort = 1'b1;		// Rollback lands one cycle later
			wr_tick();
			wr_abort = 1'b0;
		end else begin
			foreach (words[i])
				model_words.push_back(words[i]);
			model_lens.push_back(len);
			held_words += len;
			committed_pkts++;
		end
		repeat (2 + ($urandom % 4)) wr_tick();		// Gap covers commit and rollback
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Read side

	task automatic read_packet();
		int len;
		int offset;
		if (model_lens.size() == 0) begin
			error_count++;
			$display("rd_len_valid went high although no finished packet is pending");
			rd_tick();
			return;
		end
		len = model_lens[0];
		check_value("length", len, rd_len);
		repeat (len) begin
			offset    = $urandom % len;
			rd_en     = 1'b1;
			rd_offset = offset;
			rd_tick();
			rd_en = 1'b0;
			rd_tick();		// Two cycles after rd_en, word is out
			check_value("read_data", model_words[offset], rd_data);
		end
		if (($urandom % 4) == 0)
			repeat ($urandom % 16) rd_tick();	// Stall now and then so the FIFO fills
		held_words -= len;
		rd_pop = 1'b1;
		rd_tick();
		rd_pop = 1'b0;
		check_value("valid_after_pop", 1'b0, rd_len_valid);
		for (int i = 0; i < len; i++)
			model_words.delete(0);
		model_lens.delete(0);
		popped_pkts++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Run

	initial begin
		int  len;
		bit  abort;
		void'($urandom(20757));
		rd_clk   = 1'b0;
		wr_clk   = 1'b0;
		wr_reset = 1'b1;
		rd_reset = 1'b1;
		{wr_en, wr_last, wr_abort, rd_en, rd_pop} = '0;
		wr_data   = '0;
		rd_offset = '0;
		fork
			begin		// Writer
				repeat (8) @(posedge wr_clk);
				#1 wr_reset = 1'b0;
				check_value("reset_wr_size", depth, wr_size);
				for (int p = 0; p < num_packets; p++) begin
					len   = 1 + ($urandom % max_len);
					abort = ($urandom % 6) == 0;	// About one packet in six thrown away
					send_packet(len, abort);
				end
				write_done = 1'b1;
			end
			begin		// Reader
				repeat (8) @(posedge rd_clk);
				#1 rd_reset = 1'b0;
				check_value("reset_len_valid", 1'b0, rd_len_valid);
				while (!(write_done && popped_pkts == committed_pkts)) begin
					if (rd_len_valid)
						read_packet();
					else
						rd_tick();
				end
			end
		join
		// Drained, no length may show up any more
		repeat (40) begin
			rd_tick();
			check_count++;
			assert (!rd_len_valid) else begin
				error_count++;
				$display("rd_len_valid rose after the last packet was popped");
			end
		end
		repeat (10) wr_tick();
		check_value("free_space_idle", depth, wr_size);
		error_count += uut.u_seq.u_asserts.fail_count;	// Protocol checker on the sequencer
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdog_ns);
		$display("Timeout: traffic did not drain within %0d ns", watchdog_ns);
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: packet_fifo.f
verilog/packet_fifo_pkg.sv
verilog/dual_port_ram.sv
verilog/register_synchronizer.sv
verilog/cross_clock_packet_fifo.sv
verilog/packet_frame_writer.sv
verilog/packet_read_sequencer.sv
verilog/packet_fifo_top.sv
dv/packet_fifo_asserts.sv
dv/packet_fifo_tb.sv

// File: verilog/cross_clock_packet_fifo.sv
`timescale 1ns/1ns

module cross_clock_packet_fifo #(
	parameter int width = packet_fifo_pkg::default_width,
	parameter int depth = packet_fifo_pkg::default_depth,
	localparam int addr_bits = $clog2(depth)
) (
	// Write side, wr_clk domain
	input  logic                          wr_clk,
	input  logic                          wr_reset,
	input  packet_fifo_pkg::fifo_wr_ctl_t wr_ctl,
	input  logic [width-1:0]              wr_data,
	output logic [addr_bits:0]            wr_size,		// Free words, counts uncommitted ones as used

	// Read side, rd_clk domain
	input  logic                          rd_clk,
	input  logic                          rd_reset,
	input  packet_fifo_pkg::fifo_rd_ctl_t rd_ctl,
	input  logic [addr_bits-1:0]          rd_offset,		// Offset from the head for random access
	input  logic [addr_bits:0]            rd_packet_size,	// Words to drop on pop_packet
	output logic [width-1:0]              rd_data,
	output logic [addr_bits:0]            rd_size			// Committed words visible to the reader
);

	// Pointers carry one extra wrap bit for full/empty
	// Depth must be a power of two so the wrap falls out of the arithmetic
	logic [addr_bits:0]   wptr;				// Next write slot
	logic [addr_bits:0]   wptr_committed;	// Rollback target
	logic [addr_bits:0]   rptr;				// Head of the oldest word
	logic [addr_bits-1:0] rd_addr;
	logic                 rptr_updated;		// Pop happened, send rptr across
	logic [addr_bits:0]   tail_rd;			// Committed tail seen in rd_clk
	logic [addr_bits:0]   head_wr;			// Read pointer seen in wr_clk

	////////////////////////////////////////////////////////////////////////////
	// Storage

	assign rd_addr = rptr[addr_bits-1:0] + rd_offset;	// Wraps in the RAM

	dual_port_ram #(
		.width(width),
		.depth(depth)
	) u_ram (
		.wr_clk (wr_clk),
		.wr_en  (wr_ctl.wr_en),
		.wr_addr(wptr[addr_bits-1:0]),
		.wr_data(wr_data),
		.rd_clk (rd_clk),
		.rd_en  (rd_ctl.rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// Write pointer, wr_clk

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			wptr           <= '0;
			wptr_committed <= '0;
		end else begin
			if (wr_ctl.rollback)
				wptr <= wptr_committed;		// Rollback beats a push
			else if (wr_ctl.wr_en)
				wptr <= wptr + 1'b1;
			if (wr_ctl.commit)
				wptr_committed <= wptr;		// Samples the pointer before this cycle's push
		end
	end

	assign wr_size = (addr_bits + 1)'(depth) + head_wr - wptr;

	////////////////////////////////////////////////////////////////////////////
	// Read pointer, rd_clk

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			rptr         <= '0;
			rptr_updated <= 1'b0;
		end else begin
			rptr_updated <= 1'b0;
			if (rd_ctl.pop_single) begin
				if (rd_size != '0) begin	// Popping empty is ignored
					rptr         <= rptr + 1'b1;
					rptr_updated <= 1'b1;
				end
			end else if (rd_ctl.pop_packet) begin
				rptr         <= rptr + rd_packet_size;
				rptr_updated <= 1'b1;
			end
		end
	end

	assign rd_size = tail_rd - rptr;

	////////////////////////////////////////////////////////////////////////////
	// Pointer crossings

	// Committed tail into rd_clk, launched on each commit
	register_synchronizer #(
		.width(addr_bits + 1)
	) u_sync_tail (
		.clk_a    (wr_clk),
		.reset_a  (wr_reset),
		.en_a     (wr_ctl.commit),
		.reg_a    (wptr),
		.ack_a    (),
		.clk_b    (rd_clk),
		.reset_b  (rd_reset),
		.reg_b    (tail_rd),
		.updated_b()
	);

	// Head back into wr_clk, frees space after a pop
	register_synchronizer #(
		.width(addr_bits + 1)
	) u_sync_head (
		.clk_a    (rd_clk),
		.reset_a  (rd_reset),
		.en_a     (rptr_updated),
		.reg_a    (rptr),
		.ack_a    (),
		.clk_b    (wr_clk),
		.reset_b  (wr_reset),
		.reg_b    (head_wr),
		.updated_b()
	);

endmodule

// File: verilog/dual_port_ram.sv
`timescale 1ns/1ns

module dual_port_ram #(
	parameter int width = packet_fifo_pkg::default_width,
	parameter int depth = packet_fifo_pkg::default_depth,
	localparam int addr_bits = $clog2(depth)
) (
	// Write port
	input  logic                 wr_clk,
	input  logic                 wr_en,
	input  logic [addr_bits-1:0] wr_addr,
	input  logic [width-1:0]     wr_data,

	// Read port, two register stages
	input  logic                 rd_clk,
	input  logic                 rd_en,
	input  logic [addr_bits-1:0] rd_addr,
	output logic [width-1:0]     rd_data
);

	logic [width-1:0]     mem [depth];	// Storage, contents never cleared
	logic [addr_bits-1:0] rd_addr_q;	// Read address register

	////////////////////////////////////////////////////////////////////////////
	// Write port

	always_ff @(posedge wr_clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// Read port

	// Stage 1, capture address on a read strobe
	always_ff @(posedge rd_clk) begin
		if (rd_en)
			rd_addr_q <= rd_addr;
	end

	// Stage 2, output register
	// Word lands two cycles after rd_en
	always_ff @(posedge rd_clk) begin
		rd_data <= mem[rd_addr_q];
	end

endmodule

// File: verilog/packet_fifo_pkg.sv
package packet_fifo_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Default sizes

	localparam int default_width = 32;		// Data word width
	localparam int default_depth = 256;		// FIFO depth in words, power of two

	////////////////////////////////////////////////////////////////////////////
	// FIFO control bundles

	// Write side of one FIFO
	typedef struct packed {
		logic wr_en;		// Push one word
		logic commit;		// Make everything pushed so far visible
		logic rollback;		// Drop everything since the last commit
	} fifo_wr_ctl_t;

	// Read side of one FIFO
	typedef struct packed {
		logic rd_en;		// Read word at read pointer plus offset
		logic pop_single;	// Pop one word
		logic pop_packet;	// Pop rd_packet_size words
	} fifo_rd_ctl_t;

	// Read sequencer states
	typedef enum logic [1:0] {
		seq_idle,	// No length held
		seq_fetch,	// Length read issued
		seq_wait,	// RAM output register loading
		seq_ready	// rd_len valid
	} seq_state_t;

endpackage

// File: verilog/packet_fifo_top.sv
`timescale 1ns/1ns

module packet_fifo_top #(
	parameter int width = packet_fifo_pkg::default_width,
	parameter int depth = packet_fifo_pkg::default_depth,
	localparam int addr_bits = $clog2(depth)
) (
	// Write side
	input  logic                 wr_clk,
	input  logic                 wr_reset,
	input  logic                 wr_en,
	input  logic [width-1:0]     wr_data,
	input  logic                 wr_last,
	input  logic                 wr_abort,
	output logic [addr_bits:0]   wr_size,

	// Read side
	input  logic                 rd_clk,
	input  logic                 rd_reset,
	input  logic                 rd_en,
	input  logic [addr_bits-1:0] rd_offset,
	input  logic                 rd_pop,
	output logic [width-1:0]     rd_data,
	output logic [addr_bits:0]   rd_len,
	output logic                 rd_len_valid
);

	import packet_fifo_pkg::*;

	fifo_wr_ctl_t       data_wr_ctl;
	fifo_wr_ctl_t       len_wr_ctl;
	logic [addr_bits:0] len_wr_data;
	fifo_rd_ctl_t       seq_data_ctl;	// Pops from the sequencer
	fifo_rd_ctl_t       data_rd_ctl;	// Pops plus the user's read strobe
	fifo_rd_ctl_t       len_rd_ctl;
	logic [addr_bits:0] len_rd_data;
	logic [addr_bits:0] len_rd_size;

	assign data_rd_ctl.rd_en      = rd_en;
	assign data_rd_ctl.pop_single = seq_data_ctl.pop_single;
	assign data_rd_ctl.pop_packet = seq_data_ctl.pop_packet;

	packet_frame_writer #(.depth(depth)) u_writer (
		.wr_clk(wr_clk), .wr_reset(wr_reset),
		.wr_en(wr_en), .wr_last(wr_last), .wr_abort(wr_abort),
		.data_ctl(data_wr_ctl), .len_ctl(len_wr_ctl), .len_data(len_wr_data)
	);

	// Packet payload
	cross_clock_packet_fifo #(.width(width), .depth(depth)) u_data (
		.wr_clk(wr_clk), .wr_reset(wr_reset), .wr_ctl(data_wr_ctl),
		.wr_data(wr_data), .wr_size(wr_size),
		.rd_clk(rd_clk), .rd_reset(rd_reset), .rd_ctl(data_rd_ctl),
		.rd_offset(rd_offset), .rd_packet_size(rd_len),
		.rd_data(rd_data), .rd_size()
	);

	// One length word per packet, always read at the head
	cross_clock_packet_fifo #(.width(addr_bits + 1), .depth(depth)) u_len (
		.wr_clk(wr_clk), .wr_reset(wr_reset), .wr_ctl(len_wr_ctl),
		.wr_data(len_wr_data), .wr_size(),
		.rd_clk(rd_clk), .rd_reset(rd_reset), .rd_ctl(len_rd_ctl),
		.rd_offset('0), .rd_packet_size((addr_bits + 1)'(1)),
		.rd_data(len_rd_data), .rd_size(len_rd_size)
	);

	packet_read_sequencer #(.depth(depth)) u_seq (
		.rd_clk(rd_clk), .rd_reset(rd_reset), .rd_pop(rd_pop),
		.len_size(len_rd_size), .len_data(len_rd_data),
		.len_ctl(len_rd_ctl), .data_ctl(seq_data_ctl),
		.rd_len(rd_len), .rd_len_valid(rd_len_valid)
	);

endmodule

// File: verilog/packet_frame_writer.sv
`timescale 1ns/1ns

module packet_frame_writer #(
	parameter int depth = packet_fifo_pkg::default_depth,
	localparam int addr_bits = $clog2(depth)
) (
	input  logic                          wr_clk,
	input  logic                          wr_reset,
	input  logic                          wr_en,		// Word strobe
	input  logic                          wr_last,	// Word is the packet's last
	input  logic                          wr_abort,	// Throw the current packet away

	output packet_fifo_pkg::fifo_wr_ctl_t data_ctl,	// To the data FIFO
	output packet_fifo_pkg::fifo_wr_ctl_t len_ctl,	// To the length FIFO
	output logic [addr_bits:0]            len_data	// Length word of the finished packet
);

	logic [addr_bits:0] word_count;		// Words so far in the open packet
	logic               finish;			// Last word being written this cycle
	logic               data_commit_q;	// Data commit, cycle after the last word
	logic               len_commit_q;	// Length commit, one cycle later
	logic               rollback_q;		// Data rollback, cycle after abort

	assign finish = wr_en && wr_last && !wr_abort;

	////////////////////////////////////////////////////////////////////////////
	// Word counter and strobe pipeline

	always_ff @(posedge wr_clk) begin
		if (wr_reset) begin
			word_count    <= '0;
			data_commit_q <= 1'b0;
			len_commit_q  <= 1'b0;
			rollback_q    <= 1'b0;
		end else begin
			data_commit_q <= finish;
			len_commit_q  <= data_commit_q;		// Length word pushed by now
			rollback_q    <= wr_abort;
			if (wr_abort)
				word_count <= '0;
			else if (wr_en)
				word_count <= wr_last ? '0 : word_count + 1'b1;
		end
	end

	// Hold the length until the push
	always_ff @(posedge wr_clk) begin
		if (finish)
			len_data <= word_count + 1'b1;		// Count includes the last word
	end

	////////////////////////////////////////////////////////////////////////////
	// FIFO controls

	// Data FIFO, word pushes pass straight through
	always_comb begin
		data_ctl          = '0;
		data_ctl.wr_en    = wr_en;
		data_ctl.commit   = data_commit_q;
		data_ctl.rollback = rollback_q;
	end

	// Length FIFO, one word per finished packet, never rolled back
	always_comb begin
		len_ctl        = '0;
		len_ctl.wr_en  = data_commit_q;
		len_ctl.commit = len_commit_q;
	end

endmodule

// File: verilog/packet_read_sequencer.sv
`timescale 1ns/1ns

module packet_read_sequencer #(
	parameter int depth = packet_fifo_pkg::default_depth,
	localparam int addr_bits = $clog2(depth)
) (
	input  logic                          rd_clk,
	input  logic                          rd_reset,
	input  logic                          rd_pop,		// Drop the presented packet

	input  logic [addr_bits:0]            len_size,	// Lengths waiting in the length FIFO
	input  logic [addr_bits:0]            len_data,	// Length FIFO read data

	output packet_fifo_pkg::fifo_rd_ctl_t len_ctl,
	output packet_fifo_pkg::fifo_rd_ctl_t data_ctl,	// rd_en field unused, reads come from the top
	output logic [addr_bits:0]            rd_len,
	output logic                          rd_len_valid
);

	import packet_fifo_pkg::*;

	seq_state_t state;
	logic       pop_ok;		// Pop accepted this cycle

	assign rd_len_valid = (state == seq_ready);
	assign pop_ok       = rd_len_valid && rd_pop;	// Pops outside ready are dropped

	////////////////////////////////////////////////////////////////////////////
	// FSM

	always_ff @(posedge rd_clk) begin
		if (rd_reset)
			state <= seq_idle;
		else begin
			case (state)
				seq_idle:  if (len_size != '0) state <= seq_fetch;	// Read issued this cycle
				seq_fetch: state <= seq_wait;						// Address registered
				seq_wait:  state <= seq_ready;						// Output register valid
				seq_ready: if (rd_pop) state <= seq_idle;
				default:   state <= seq_idle;
			endcase
		end
	end

	// Latch the length as the RAM output settles
	always_ff @(posedge rd_clk) begin
		if (state == seq_wait)
			rd_len <= len_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// FIFO controls

	always_comb begin
		len_ctl            = '0;
		len_ctl.rd_en      = (state == seq_idle) && (len_size != '0);	// Offset 0, oldest length
		len_ctl.pop_single = pop_ok;
	end

	// Whole packet leaves with its length word, same cycle
	always_comb begin
		data_ctl            = '0;
		data_ctl.pop_packet = pop_ok;
	end

endmodule

// File: verilog/register_synchronizer.sv
`timescale 1ns/1ns

module register_synchronizer #(
	parameter int width = 8
) (
	// Source domain
	input  logic             clk_a,
	input  logic             reset_a,
	input  logic             en_a,		// Send reg_a
	input  logic [width-1:0] reg_a,
	output logic             ack_a,		// Pulse when a transfer has landed

	// Destination domain
	input  logic             clk_b,
	input  logic             reset_b,
	output logic [width-1:0] reg_b,
	output logic             updated_b	// Pulse when reg_b loads
);

	logic [width-1:0] hold_a;		// Value in flight, stable until acked
	logic [width-1:0] next_a;		// Latest value queued behind a busy transfer
	logic             tog_a;		// Request toggle
	logic             busy_a;		// Transfer outstanding
	logic             pend_a;		// next_a waiting to go
	logic             free_a;		// A new transfer may launch this cycle
	logic [2:0]       ack_sync_a;	// Return toggle, two sync flops plus edge flop
	logic [2:0]       tog_sync_b;	// Request toggle, two sync flops plus edge flop
	logic             tog_b;		// Return toggle
	logic             edge_b;

	////////////////////////////////////////////////////////////////////////////
	// Source side

	assign ack_a  = ack_sync_a[1] ^ ack_sync_a[2];
	assign free_a = !busy_a || ack_a;	// Ack frees the slot in the same cycle

	always_ff @(posedge clk_a) begin
		if (reset_a) begin
			tog_a      <= 1'b0;
			busy_a     <= 1'b0;
			pend_a     <= 1'b0;
			ack_sync_a <= '0;
		end else begin
			ack_sync_a <= {ack_sync_a[1:0], tog_b};
			if (free_a && (en_a || pend_a)) begin	// Fresh value beats a queued one
				tog_a  <= !tog_a;
				busy_a <= 1'b1;
				pend_a <= 1'b0;
			end else if (ack_a)
				busy_a <= 1'b0;
			if (en_a && !free_a)
				pend_a <= 1'b1;		// Hold it, send after the ack
		end
	end

	// Payload capture
	always_ff @(posedge clk_a) begin
		if (en_a && free_a)
			hold_a <= reg_a;
		else if (pend_a && free_a)
			hold_a <= next_a;
		if (en_a && !free_a)
			next_a <= reg_a;
	end

	////////////////////////////////////////////////////////////////////////////
	// Destination side

	assign edge_b = tog_sync_b[1] ^ tog_sync_b[2];
	assign tog_b  = tog_sync_b[2];		// Echo back once reg_b has loaded

	always_ff @(posedge clk_b) begin
		if (reset_b) begin
			tog_sync_b <= '0;
			reg_b      <= '0;
			updated_b  <= 1'b0;
		end else begin
			tog_sync_b <= {tog_sync_b[1:0], tog_a};
			updated_b  <= edge_b;
			if (edge_b)
				reg_b <= hold_a;	// hold_a has been stable for two clk_b cycles
		end
	end

endmodule
